/* source/msg_pkg.sv */
`default_nettype none

package msg_pkg;

  localparam int XB_SIZE  = 32;  // host word
  localparam int FDS_SIZE = 20;  // camera sample data

  // kind codes in the two low bits of every host word
  localparam logic [1:0] KIND_PIXEL = 2'd0;
  localparam logic [1:0] KIND_END   = 2'd1;  // last coefficient word

  localparam int N_ROW_BITS   = 12;
  localparam int N_COL_BITS   = 11;
  localparam int N_FRAME_BITS = 20;

  // pixel tracker states
  localparam int PIX_STATE_BITS = 2;
  localparam logic [PIX_STATE_BITS-1:0] PIX_STANDBY    = 2'd0;
  localparam logic [PIX_STATE_BITS-1:0] PIX_INTERFRAME = 2'd1;
  localparam logic [PIX_STATE_BITS-1:0] PIX_INTRALINE  = 2'd2;
  localparam logic [PIX_STATE_BITS-1:0] PIX_INTERLINE  = 2'd3;

  // one host word, seen either as a camera sample or as a control word
  typedef union packed {
    struct packed {
      logic [FDS_SIZE-1:0] fds;
      logic [5:0]          rsvd_hi;
      logic                fval;
      logic                lval;
      logic [1:0]          rsvd_lo;
      logic [1:0]          kind;
    } pix;
    struct packed {
      logic [XB_SIZE-3:0]  payload;
      logic [1:0]          kind;
    } ctl;
  } xb_word_t;

endpackage

`default_nettype wire

/* source/dram_pkg.sv */
`default_nettype none

package dram_pkg;

  localparam int APP_DATA_WIDTH = 64;  // one write beat
  localparam int ADDR_WIDTH     = 27;

  localparam logic [ADDR_WIDTH-1:0] START_ADDR = '0;
  localparam logic [ADDR_WIDTH-1:0] ADDR_INC   = 27'd8;  // BL8, one burst

  // host words per two-beat burst
  localparam int BURST_WORDS    = 4;
  localparam int BURST_CNT_BITS = 2;

  // write port states
  localparam int WR_STATE_BITS = 2;
  localparam logic [WR_STATE_BITS-1:0] WR_IDLE  = 2'd0;
  localparam logic [WR_STATE_BITS-1:0] WR_CMD   = 2'd1;  // app_en up, waiting for rdy
  localparam logic [WR_STATE_BITS-1:0] WR_BEAT1 = 2'd2;
  localparam logic [WR_STATE_BITS-1:0] WR_BEAT2 = 2'd3;

endpackage

`default_nettype wire

/* source/msg_fifo_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface msg_fifo_if import msg_pkg::*; ();

  logic     push;
  xb_word_t wdata;
  logic     almost_full;
  logic     pop;
  xb_word_t rdata;        // oldest word, valid while empty is low
  logic     empty;

  modport producer (
    output push, wdata,
    input  almost_full
  );

  modport consumer (
    output pop,
    input  rdata, empty
  );

  modport store (
    input  push, wdata, pop,
    output almost_full, rdata, empty
  );

endinterface

`default_nettype wire

/* source/dram_burst_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dram_burst_if import dram_pkg::*; ();

  logic                      valid;
  logic [APP_DATA_WIDTH-1:0] beat0;
  logic [APP_DATA_WIDTH-1:0] beat1;
  logic                      final_burst;  // last burst of the coefficient set
  logic                      taken;        // one-cycle retire pulse from the sink

  modport source (
    output valid, beat0, beat1, final_burst,
    input  taken
  );

  modport sink (
    input  valid, beat0, beat1, final_burst,
    output taken
  );

endinterface

`default_nettype wire

/* source/msg_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_fifo import msg_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic      bus_clk,
  input  logic      fds_val,
  msg_fifo_if.store q
);

  xb_word_t                 mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH):0]   count;

  assign q.rdata = mem[rd_ptr];
  assign q.empty = (count == 0);
  // two slots of margin, one of them for the word still in the router register
  assign q.almost_full = (count >= DEPTH - 2);

  always_ff @(posedge bus_clk) begin
    if (q.push) begin
      mem[wr_ptr] <= q.wdata;
    end
  end

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (q.push) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps, DEPTH is a power of two
      end
      if (q.pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({q.push, q.pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge bus_clk) disable iff (fds_val)
    q.push && !q.pop |-> count < DEPTH)
    else $error("msg_fifo: push into full fifo");

  a_no_underflow: assert property (@(posedge bus_clk) disable iff (fds_val)
    q.pop |-> !q.empty)
    else $error("msg_fifo: pop from empty fifo");

endmodule

`default_nettype wire

/* source/msg_router.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_router import msg_pkg::*, dram_pkg::*; (
  input  logic         bus_clk,
  input  logic         fds_val,
  input  logic         pc_msg_empty,
  input  xb_word_t     pc_msg,
  output logic         pc_msg_ack,
  msg_fifo_if.producer pix_q,
  msg_fifo_if.producer coef_q
);

  logic [BURST_CNT_BITS-1:0] n_coef;  // coefficient words seen, mod BURST_WORDS
  logic                      is_pix;
  logic                      pend_d;
  logic                      is_pix_d;
  xb_word_t                  word_d;

  // back-pressure when either fifo runs low on room
  assign pc_msg_ack = !pc_msg_empty && !pix_q.almost_full && !coef_q.almost_full;

  // a kind 0 word in the middle of a burst is still coefficient data
  assign is_pix = (pc_msg.ctl.kind == KIND_PIXEL) && (n_coef == '0);

  assign pix_q.push  = pend_d && is_pix_d;
  assign coef_q.push = pend_d && !is_pix_d;
  assign pix_q.wdata  = word_d;
  assign coef_q.wdata = word_d;

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      n_coef   <= '0;
      pend_d   <= 1'b0;
      is_pix_d <= 1'b0;
    end else begin
      pend_d <= pc_msg_ack;
      if (pc_msg_ack) begin
        is_pix_d <= is_pix;
        if (!is_pix) begin
          n_coef <= (n_coef == BURST_WORDS - 1) ? '0 : n_coef + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (pc_msg_ack) begin
      word_d <= pc_msg;  // lines up with is_pix_d
    end
  end

  // only the one word still in the register may land in an almost full fifo
  a_push_had_room: assert property (@(posedge bus_clk) disable iff (fds_val)
    (pix_q.push && pix_q.almost_full |-> !$past(pix_q.push && pix_q.almost_full)) and
    (coef_q.push && coef_q.almost_full |-> !$past(coef_q.push && coef_q.almost_full)))
    else $error("msg_router: word accepted into almost full fifo");

endmodule

`default_nettype wire

/* source/pixel_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_tracker import msg_pkg::*; (
  input  logic                    bus_clk,
  input  logic                    fds_val,
  msg_fifo_if.consumer            pix_q,
  output logic                    pix_valid,
  output logic [FDS_SIZE-1:0]     pix_fds,
  output logic [N_ROW_BITS-1:0]   pix_row,
  output logic [N_COL_BITS-1:0]   pix_col,
  output logic [N_FRAME_BITS-1:0] frame_count
);

  xb_word_t                  w;
  logic [PIX_STATE_BITS-1:0] state;
  logic [N_ROW_BITS-1:0]     n_row;    // row within the frame
  logic [N_COL_BITS-1:0]     n_col;    // column of the next sample in the line
  logic [N_COL_BITS-1:0]     col_now;
  logic                      emit;

  // samples keep flowing, take every one as soon as it is there
  assign pix_q.pop = !pix_q.empty;
  assign w = pix_q.rdata;

  assign col_now = (state == PIX_INTRALINE) ? n_col : '0;  // first sample of a line is col 0
  assign emit = pix_q.pop && w.pix.lval && (state != PIX_STANDBY);

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state       <= PIX_STANDBY;
      pix_valid   <= 1'b0;
      n_row       <= '0;
      n_col       <= '0;
      frame_count <= '0;
    end else begin
      pix_valid <= emit;
      if (emit) begin
        n_col <= col_now + 1'b1;
      end
      if (pix_q.pop) begin
        case (state)
          PIX_STANDBY: begin
            // wait for a frame gap before trusting the counters
            if (!w.pix.fval) begin
              state <= PIX_INTERFRAME;
            end
          end
          PIX_INTRALINE: begin
            if (!w.pix.lval) begin
              if (w.pix.fval) begin
                n_row <= n_row + 1'b1;
                state <= PIX_INTERLINE;
              end else begin
                n_row       <= '0;  // end of frame
                frame_count <= frame_count + 1'b1;
                state       <= PIX_INTERFRAME;
              end
            end
          end
          default: begin
            // interframe and interline both open a line on lval
            if (w.pix.lval) begin
              state <= PIX_INTRALINE;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (emit) begin
      pix_fds <= w.pix.fds;
      pix_row <= n_row;
      pix_col <= col_now;
    end
  end

endmodule

`default_nettype wire

/* source/burst_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_assembler import msg_pkg::*, dram_pkg::*; (
  input  logic         bus_clk,
  input  logic         fds_val,
  msg_fifo_if.consumer coef_q,
  dram_burst_if.source burst
);

  logic [BURST_WORDS*XB_SIZE-1:0] pack_q;  // word 0 in the low bits
  logic [BURST_CNT_BITS-1:0]      cnt;     // next slot to fill
  logic                           full_q;
  logic                           done_q;  // end marker handed over
  xb_word_t                       last_w;

  assign coef_q.pop = !coef_q.empty && !full_q && !done_q;

  assign last_w = pack_q[(BURST_WORDS-1)*XB_SIZE +: XB_SIZE];

  assign burst.valid       = full_q;
  assign burst.beat0       = pack_q[0 +: APP_DATA_WIDTH];
  assign burst.beat1       = pack_q[APP_DATA_WIDTH +: APP_DATA_WIDTH];
  assign burst.final_burst = (last_w.ctl.kind == KIND_END);

  always_ff @(posedge bus_clk) begin
    if (coef_q.pop) begin
      pack_q[cnt*XB_SIZE +: XB_SIZE] <= coef_q.rdata;
    end
  end

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      cnt    <= '0;
      full_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      if (coef_q.pop) begin
        cnt <= cnt + 1'b1;  // wraps back to slot 0
        if (cnt == BURST_WORDS - 1) begin
          full_q <= 1'b1;
        end
      end
      if (burst.taken) begin
        full_q <= 1'b0;
        if (burst.final_burst) begin
          done_q <= 1'b1;  // nothing after the end marker is written
        end
      end
    end
  end

  // the write port reads beat0 and beat1 in different cycles
  a_burst_held: assert property (@(posedge bus_clk) disable iff (fds_val)
    burst.valid && !burst.taken |=>
      burst.valid && $stable(burst.beat0) && $stable(burst.beat1))
    else $error("burst_assembler: burst changed before taken");

endmodule

`default_nettype wire

/* source/dram_write_port.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_write_port import dram_pkg::*; (
  input  logic                      bus_clk,
  input  logic                      fds_val,
  dram_burst_if.sink                burst,
  input  logic                      app_rdy,
  input  logic                      app_wdf_rdy,
  output logic                      app_en,
  output logic                      app_wdf_wren,
  output logic                      app_wdf_end,
  output logic                      app_done,
  output logic [ADDR_WIDTH-1:0]     app_addr,
  output logic [APP_DATA_WIDTH-1:0] app_wdf_data
);

  logic [WR_STATE_BITS-1:0] state;
  logic                     final_q;  // current burst carries the end marker
  logic                     load0;
  logic                     load1;

  // command and first data slot accepted together
  assign load0 = (state == WR_CMD) && app_rdy && app_wdf_rdy;
  assign load1 = (state == WR_BEAT1) && app_wdf_rdy;  // beat0 taken

  always_ff @(posedge bus_clk) begin
    if (load0) begin
      app_wdf_data <= burst.beat0;
    end else if (load1) begin
      app_wdf_data <= burst.beat1;
    end
  end

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state        <= WR_IDLE;
      final_q      <= 1'b0;
      app_en       <= 1'b0;
      app_wdf_wren <= 1'b0;
      app_wdf_end  <= 1'b1;
      app_done     <= 1'b0;
      app_addr     <= START_ADDR;
      burst.taken  <= 1'b0;
    end else begin
      burst.taken <= load1;  // pulses with beat1 on the bus
      case (state)
        WR_IDLE: begin
          if (burst.valid && !app_done) begin
            app_en  <= 1'b1;
            final_q <= burst.final_burst;
            state   <= WR_CMD;
          end
        end
        WR_CMD: begin
          if (load0) begin
            app_en       <= 1'b0;
            app_addr     <= app_addr + ADDR_INC;  // ready for the next burst
            app_wdf_wren <= 1'b1;
            app_wdf_end  <= 1'b0;
            state        <= WR_BEAT1;
          end
        end
        WR_BEAT1: begin
          if (load1) begin
            app_wdf_end <= 1'b1;
            state       <= WR_BEAT2;
          end
        end
        default: begin
          if (app_wdf_rdy) begin
            app_wdf_wren <= 1'b0;
            if (final_q) begin
              app_done <= 1'b1;  // sticky
            end
            state <= WR_IDLE;
          end
        end
      endcase
    end
  end

  a_cmd_held: assert property (@(posedge bus_clk) disable iff (fds_val)
    app_en && !app_rdy |=> app_en && $stable(app_addr))
    else $error("dram_write_port: command dropped or moved while app_rdy low");

endmodule

`default_nettype wire

/* source/patch_app_top.sv */
`timescale 1ns/1ps
`default_nettype none

module patch_app_top import msg_pkg::*, dram_pkg::*; (
  input  logic                      bus_clk,
  input  logic                      fds_val,
  // host message source
  input  logic                      pc_msg_empty,
  input  logic [XB_SIZE-1:0]        pc_msg,
  output logic                      pc_msg_ack,
  // tracked camera samples
  output logic                      pix_valid,
  output logic [FDS_SIZE-1:0]       pix_fds,
  output logic [N_ROW_BITS-1:0]     pix_row,
  output logic [N_COL_BITS-1:0]     pix_col,
  output logic [N_FRAME_BITS-1:0]   frame_count,
  // memory controller application port
  input  logic                      app_rdy,
  input  logic                      app_wdf_rdy,
  output logic                      app_en,
  output logic                      app_wdf_wren,
  output logic                      app_wdf_end,
  output logic                      app_done,
  output logic [ADDR_WIDTH-1:0]     app_addr,
  output logic [APP_DATA_WIDTH-1:0] app_wdf_data
);

  msg_fifo_if   pix_if ();
  msg_fifo_if   coef_if ();
  dram_burst_if burst_if ();

  msg_router u_router (
    .bus_clk      (bus_clk),
    .fds_val      (fds_val),
    .pc_msg_empty (pc_msg_empty),
    .pc_msg       (pc_msg),
    .pc_msg_ack   (pc_msg_ack),
    .pix_q        (pix_if),
    .coef_q       (coef_if)
  );

  msg_fifo u_pix_fifo (
    .bus_clk (bus_clk),
    .fds_val (fds_val),
    .q       (pix_if)
  );

  msg_fifo u_coef_fifo (
    .bus_clk (bus_clk),
    .fds_val (fds_val),
    .q       (coef_if)
  );

  pixel_tracker u_pixel_tracker (
    .bus_clk     (bus_clk),
    .fds_val     (fds_val),
    .pix_q       (pix_if),
    .pix_valid   (pix_valid),
    .pix_fds     (pix_fds),
    .pix_row     (pix_row),
    .pix_col     (pix_col),
    .frame_count (frame_count)
  );

  burst_assembler u_burst_assembler (
    .bus_clk (bus_clk),
    .fds_val (fds_val),
    .coef_q  (coef_if),
    .burst   (burst_if)
  );

  dram_write_port u_dram_write_port (
    .bus_clk      (bus_clk),
    .fds_val      (fds_val),
    .burst        (burst_if),
    .app_rdy      (app_rdy),
    .app_wdf_rdy  (app_wdf_rdy),
    .app_en       (app_en),
    .app_wdf_wren (app_wdf_wren),
    .app_wdf_end  (app_wdf_end),
    .app_done     (app_done),
    .app_addr     (app_addr),
    .app_wdf_data (app_wdf_data)
  );

endmodule

`default_nettype wire

/* tests/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top import msg_pkg::*, dram_pkg::*; ();

  localparam int SEED         = 46425;
  localparam int RESET_CYCLES = 16;
  localparam int N_FRAMES     = 3;
  localparam int N_LINES      = 3;
  localparam int TAIL_WORDS   = 10;   // more than the coefficient fifo can take
  localparam int HOLD_CYCLES  = 100;
  localparam int END_CYCLES   = 20;
  localparam int MAX_WORDS    = 256;

  logic                      bus_clk = 1'b0;
  logic                      fds_val;
  logic                      pc_msg_empty;
  logic [XB_SIZE-1:0]        pc_msg;
  logic                      pc_msg_ack;
  logic                      pix_valid;
  logic [FDS_SIZE-1:0]       pix_fds;
  logic [N_ROW_BITS-1:0]     pix_row;
  logic [N_COL_BITS-1:0]     pix_col;
  logic [N_FRAME_BITS-1:0]   frame_count;
  logic                      app_rdy;
  logic                      app_wdf_rdy;
  logic                      app_en;
  logic                      app_wdf_wren;
  logic                      app_wdf_end;
  logic                      app_done;
  logic [ADDR_WIDTH-1:0]     app_addr;
  logic [APP_DATA_WIDTH-1:0] app_wdf_data;

  // stimulus and reference model
  logic [XB_SIZE-1:0]        words [MAX_WORDS];
  int                        gaps [MAX_WORDS];
  logic [FDS_SIZE-1:0]       exp_fds [MAX_WORDS];
  int                        exp_row [MAX_WORDS];
  int                        exp_col [MAX_WORDS];
  int                        exp_frame [MAX_WORDS];
  logic [APP_DATA_WIDTH-1:0] exp_beat [64];
  int n_words = 0;
  int n_main = 0;
  int n_exp_pix = 0;
  int n_exp_beat = 0;
  int n_exp_burst = 0;
  int plan_cycles = 0;

  // monitor state
  int   n_pix = 0;
  int   n_beat = 0;
  int   n_cmd = 0;
  int   checks = 0;
  int   errors = 0;
  int   cycles = 0;
  int   limit = 0;
  logic took = 1'b0;             // ack seen at the last rising edge
  logic held_after_done = 1'b0;

  patch_app_top u_dut (.*);

  always #5 bus_clk = ~bus_clk;

  function automatic logic [XB_SIZE-1:0] sample_word(input logic [FDS_SIZE-1:0] fds,
                                                     input logic fval, input logic lval);
    sample_word = {fds, 6'd0, fval, lval, 2'd0, KIND_PIXEL};
  endfunction

  function automatic int pick_gap();
    pick_gap = ($urandom % 4 == 0) ? 1 + $urandom % 3 : 0;
  endfunction

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("Mismatch at %0t ns: %s", $time, msg);
  endtask

  task automatic queue_word(input logic [XB_SIZE-1:0] w, input int gap);
    words[n_words] = w;
    gaps[n_words] = gap;
    plan_cycles += gap + 1;
    n_words++;
  endtask

  task automatic queue_line(input int frame, input int row, input bit last_row);
    int                  ncols;
    int                  c;
    logic [FDS_SIZE-1:0] fds;
    ncols = 2 + $urandom % 4;
    for (c = 0; c < ncols; c++) begin
      fds = FDS_SIZE'($urandom);
      exp_fds[n_exp_pix] = fds;
      exp_row[n_exp_pix] = row;
      exp_col[n_exp_pix] = c;
      exp_frame[n_exp_pix] = frame;
      n_exp_pix++;
      queue_word(sample_word(fds, 1'b1, 1'b1), pick_gap());
    end
    // fval low on the line end closes the frame
    queue_word(sample_word(FDS_SIZE'($urandom), !last_row, 1'b0), pick_gap());
  endtask

  task automatic queue_group(input bit last_group);
    logic [XB_SIZE-1:0] w [4];
    logic [1:0]         kind;
    int                 i;
    for (i = 0; i < BURST_WORDS; i++) begin
      kind = 2'($urandom);  // kind 0 inside a group is still coefficient data
      if (i == 0) begin
        kind = 2'd2 + kind[0];
      end else if (i == BURST_WORDS - 1) begin
        kind = last_group ? KIND_END : ((kind == KIND_END) ? 2'd3 : kind);
      end
      w[i] = {30'($urandom), kind};
      queue_word(w[i], pick_gap());
    end
    exp_beat[n_exp_beat] = {w[1], w[0]};
    exp_beat[n_exp_beat + 1] = {w[3], w[2]};
    n_exp_beat += 2;
    n_exp_burst++;
  endtask

  task automatic build_stream();
    int f;
    int r;
    queue_word(sample_word('0, 1'b0, 1'b0), 0);  // frame gap takes the tracker out of standby
    for (f = 0; f < N_FRAMES; f++) begin
      for (r = 0; r < N_LINES; r++) begin
        queue_line(f, r, r == N_LINES - 1);
        queue_group(1'b0);
      end
      queue_word(sample_word(FDS_SIZE'($urandom), 1'b0, 1'b0), pick_gap());
    end
    queue_group(1'b1);
    n_main = n_words;
    for (f = 0; f < TAIL_WORDS; f++) begin
      queue_word({30'($urandom), 2'd3}, 0);
    end
  endtask

  // called on a falling edge, returns on the falling edge after the word went in
  task automatic send_word(input logic [XB_SIZE-1:0] w, input int gap, input int max_wait,
                           output bit accepted);
    int waited;
    waited = 0;
    repeat (gap) begin
      pc_msg_empty = 1'b1;
      @(negedge bus_clk);
    end
    pc_msg_empty = 1'b0;
    pc_msg = w;
    @(negedge bus_clk);
    while (!took && waited < max_wait) begin
      waited++;
      @(negedge bus_clk);
    end
    accepted = took;
  endtask

  task automatic drive_ready();
    forever begin
      @(negedge bus_clk);
      app_rdy = ($urandom % 10) < 7;
      app_wdf_rdy = ($urandom % 10) < 7;
    end
  endtask

  always @(posedge bus_clk) begin
    took <= pc_msg_ack;
    if (!fds_val) begin
      if (pix_valid) n_pix <= n_pix + 1;
      if (app_wdf_wren && app_wdf_rdy) n_beat <= n_beat + 1;
      if (app_en && app_rdy && app_wdf_rdy) n_cmd <= n_cmd + 1;
      if (app_done && !pc_msg_empty && !pc_msg_ack) held_after_done <= 1'b1;
      checks <= checks + int'(pix_valid) + int'(app_wdf_wren && app_wdf_rdy)
                + int'(app_en && app_rdy && app_wdf_rdy);
    end
  end

  always @(posedge bus_clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  a_pixel: assert property (@(posedge bus_clk) disable iff (fds_val)
    pix_valid |-> n_pix < n_exp_pix && pix_fds == exp_fds[n_pix] && pix_row == exp_row[n_pix]
      && pix_col == exp_col[n_pix] && frame_count == exp_frame[n_pix])
    else flag_mismatch($sformatf("sample %0d got fds %h row %0d col %0d frame %0d",
      $sampled(n_pix), $sampled(pix_fds), $sampled(pix_row), $sampled(pix_col),
      $sampled(frame_count)));

  a_beat: assert property (@(posedge bus_clk) disable iff (fds_val)
    app_wdf_wren && app_wdf_rdy |-> n_beat < n_exp_beat
      && app_wdf_data == exp_beat[n_beat] && app_wdf_end == (n_beat % 2 == 1))
    else flag_mismatch($sformatf("beat %0d got data %h end %b",
      $sampled(n_beat), $sampled(app_wdf_data), $sampled(app_wdf_end)));

  a_cmd_addr: assert property (@(posedge bus_clk) disable iff (fds_val)
    app_en && app_rdy && app_wdf_rdy |-> n_cmd < n_exp_burst && n_beat == 2 * n_cmd
      && app_addr == ADDR_WIDTH'(START_ADDR + ADDR_INC * n_cmd))
    else flag_mismatch($sformatf("command %0d at address %h after %0d beats",
      $sampled(n_cmd), $sampled(app_addr), $sampled(n_beat)));

  a_cmd_held: assert property (@(posedge bus_clk) disable iff (fds_val)
    app_en && !(app_rdy && app_wdf_rdy) |=> app_en && $stable(app_addr))
    else flag_mismatch("command moved before it was accepted");

  a_end_with_wren: assert property (@(posedge bus_clk) disable iff (fds_val)
    $rose(app_wdf_end) |-> app_wdf_wren)
    else flag_mismatch("app_wdf_end rose without app_wdf_wren");

  a_done_quiet: assert property (@(posedge bus_clk) disable iff (fds_val)
    app_done |-> !app_en ##1 app_done)
    else flag_mismatch("app_done dropped or a command followed it");

  a_backpressure: assert property (@(posedge bus_clk) disable iff (fds_val)
    held_after_done |-> !pc_msg_ack)
    else flag_mismatch("pc_msg_ack rose after the coefficient fifo filled");

  initial begin
    bit ok;
    fds_val = 1'b1;
    pc_msg_empty = 1'b1;
    pc_msg = '0;
    app_rdy = 1'b0;
    app_wdf_rdy = 1'b0;
    void'($urandom(SEED));
    build_stream();
    limit = 4 * (RESET_CYCLES + plan_cycles + HOLD_CYCLES + END_CYCLES);
    fork
      drive_ready();
    join_none
    repeat (RESET_CYCLES) @(negedge bus_clk);
    assert (!app_en && !app_wdf_wren && app_wdf_end && !pix_valid && !app_done
            && app_addr == START_ADDR)
      else flag_mismatch("outputs not at their reset values");
    fds_val = 1'b0;
    for (int i = 0; i < n_main; i++) begin
      send_word(words[i], gaps[i], limit, ok);
    end
    // tail behind the end marker, expected to stall once the fifo fills
    for (int i = n_main; i < n_words; i++) begin
      send_word(words[i], 0, HOLD_CYCLES, ok);
      if (!ok) break;
    end
    while (!app_done) @(negedge bus_clk);
    repeat (END_CYCLES) @(negedge bus_clk);
    assert (n_pix == n_exp_pix)
      else flag_mismatch($sformatf("%0d samples seen, %0d expected", n_pix, n_exp_pix));
    assert (n_cmd == n_exp_burst && n_beat == n_exp_beat)
      else flag_mismatch($sformatf("%0d commands and %0d beats seen", n_cmd, n_beat));
    assert (held_after_done) else begin
      errors++;
      $display("back-pressure never held a pending word after app_done");
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
source/msg_pkg.sv
source/dram_pkg.sv
source/msg_fifo_if.sv
source/dram_burst_if.sv
source/msg_fifo.sv
source/msg_router.sv
source/pixel_tracker.sv
source/burst_assembler.sv
source/dram_write_port.sv
source/patch_app_top.sv
tests/tb_top.sv
